// ==== Makefile ====
SIM := obj_dir/VcpuCoreTb

.PHONY: all run clean

all: run

$(SIM): compile.f $(wildcard rtl/*.sv testbench/*.sv)
	verilator --binary --timing -Wno-fatal --top-module cpuCoreTb -f compile.f -o VcpuCoreTb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Simulation passed'

clean:
	rm -rf obj_dir

// ==== compile.f ====
rtl/cpuPkg.sv
rtl/ID.sv
rtl/alu.sv
rtl/regFile.sv
rtl/fetch.sv
rtl/instrQueue.sv
rtl/execute.sv
rtl/cpuCore.sv
testbench/cpuCoreTb.sv

// ==== rtl/ID.sv ====
`timescale 1ns/1ps

module ID (
  input  cpuPkg::word_t       instr,
  output logic [11:0]         imm,
  output cpuPkg::regAddr_t    p0Addr,
  output cpuPkg::regAddr_t    p1Addr,
  output cpuPkg::regAddr_t    regAddr,
  output cpuPkg::regAddr_t    shamt,
  output cpuPkg::aluOp_t      aluOp,
  output cpuPkg::branchCond_t branchOp,
  output logic                regWe,
  output logic                memRe,
  output logic                memWe,
  output logic                memToReg,
  output logic                addz,
  output logic                branch,
  output logic                jal,
  output logic                jr,
  output logic                aluSrc0,
  output logic                aluSrc1,
  output logic                ovEn,
  output logic                zrEn,
  output logic                neEn,
  output logic                halt
);

  cpuPkg::opcode_t op;
  logic isAdd, isSub, isLw, isSw, isLhb, isLlb;

  assign op = cpuPkg::opcode_t'(instr[15:12]);

  // One-hot opcode matches
  assign isAdd  = op == cpuPkg::opAdd;
  assign addz   = op == cpuPkg::opAddz;
  assign isSub  = op == cpuPkg::opSub;
  assign isLw   = op == cpuPkg::opLw;
  assign isSw   = op == cpuPkg::opSw;
  assign isLhb  = op == cpuPkg::opLhb;
  assign isLlb  = op == cpuPkg::opLlb;
  assign branch = op == cpuPkg::opBranch;
  assign jal    = op == cpuPkg::opJal;
  assign jr     = op == cpuPkg::opJr;
  assign halt   = op == cpuPkg::opHalt;

  assign imm   = instr[11:0];
  assign shamt = instr[3:0];

  // lhb reads its own destination so the low byte survives
  assign p0Addr = isLhb ? instr[11:8] : instr[7:4];
  // Store data and lhb destination sit in [11:8], llb pairs the immediate with R0
  assign p1Addr = (isSw | isLhb) ? instr[11:8] :
                  isLw ? instr[7:4] :
                  isLlb ? 4'h0 : instr[3:0];

  // jal links into R15
  assign regAddr = jal ? 4'hf : instr[11:8];

  // addz write is further qualified by the zero flag in execute
  assign regWe    = !isSw & !branch & !jr & !halt;
  assign memRe    = isLw;
  assign memWe    = isSw;
  assign memToReg = isLw;

  // Arithmetic sets all flags, logic and shifts set only zero
  assign ovEn = isAdd | addz | isSub;
  assign zrEn = !instr[15];
  assign neEn = ovEn;

  // Immediate byte operand vs 4-bit address offset
  assign aluSrc0 = isLlb | isLhb;
  assign aluSrc1 = isLw | isSw;

  assign branchOp = cpuPkg::branchCond_t'(instr[11:9]);

  // addz shares add, memory and jumps use add too
  assign aluOp = !instr[15] ? (addz ? cpuPkg::aluAdd : cpuPkg::aluOp_t'(instr[14:12])) :
                 isLhb ? cpuPkg::aluLhb : cpuPkg::aluAdd;

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  cpuPkg::word_t    a,
  input  cpuPkg::word_t    b,
  input  cpuPkg::aluOp_t   aluOp,
  input  cpuPkg::regAddr_t shamt,
  output cpuPkg::word_t    result,
  output logic             ov,
  output logic             zr,
  output logic             ne
);

  cpuPkg::word_t sum;
  cpuPkg::word_t diff;

  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    result = '0;
    ov     = 1'b0;
    case (aluOp)
      cpuPkg::aluAdd: begin
        result = sum;
        // Same-sign operands with a flipped result sign
        ov     = (a[15] == b[15]) && (sum[15] != a[15]);
      end
      cpuPkg::aluSub: begin
        result = diff;
        ov     = (a[15] != b[15]) && (diff[15] != a[15]);
      end
      cpuPkg::aluAnd: result = a & b;
      cpuPkg::aluNor: result = ~(a | b);
      cpuPkg::aluSll: result = a << shamt;
      cpuPkg::aluSrl: result = a >> shamt;
      cpuPkg::aluSra: result = cpuPkg::word_t'($signed(a) >>> shamt);
      // Immediate byte on top, register low byte kept
      cpuPkg::aluLhb: result = {b[7:0], a[7:0]};
      default: result = '0;
    endcase
  end

  assign zr = result == '0;
  assign ne = result[15];

endmodule

// ==== rtl/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore #(
  parameter int queueDepth = 4
) (
  input  logic             clk,
  input  logic             rstN,
  output cpuPkg::addr_t    instrAddr,
  input  cpuPkg::word_t    instrData,
  output logic             memReq,
  output logic             memWe,
  output cpuPkg::addr_t    memAddr,
  output cpuPkg::word_t    memWdata,
  input  cpuPkg::word_t    memRdata,
  input  logic             memReady,
  output logic             retireValid,
  output logic             retireWe,
  output cpuPkg::addr_t    retirePc,
  output cpuPkg::regAddr_t retireReg,
  output cpuPkg::word_t    retireData,
  output logic             halted
);

  // Fetch to queue
  logic          push, creditReturn;
  cpuPkg::word_t pushInstr;
  cpuPkg::addr_t pushPc;
  // Queue to execute
  logic          pop, notEmpty;
  cpuPkg::word_t headInstr;
  cpuPkg::addr_t headPc;
  // Redirect also flushes the queue
  logic          redirect;
  cpuPkg::addr_t redirectTarget;

  fetch #(.queueDepth(queueDepth)) fetchUnit (
    .clk(clk), .rstN(rstN), .creditReturn(creditReturn), .redirect(redirect),
    .redirectTarget(redirectTarget), .instrAddr(instrAddr), .instrData(instrData),
    .push(push), .pushInstr(pushInstr), .pushPc(pushPc)
  );

  instrQueue #(.queueDepth(queueDepth)) queue (
    .clk(clk), .rstN(rstN), .push(push), .pop(pop), .flush(redirect),
    .pushInstr(pushInstr), .pushPc(pushPc), .notEmpty(notEmpty),
    .creditReturn(creditReturn), .headInstr(headInstr), .headPc(headPc)
  );

  execute exec (
    .clk(clk), .rstN(rstN), .notEmpty(notEmpty), .headInstr(headInstr),
    .headPc(headPc), .pop(pop), .redirect(redirect), .redirectTarget(redirectTarget),
    .memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
    .memRdata(memRdata), .memReady(memReady), .retireValid(retireValid),
    .retireWe(retireWe), .retirePc(retirePc), .retireReg(retireReg),
    .retireData(retireData), .halted(halted)
  );

endmodule

// ==== rtl/cpuPkg.sv ====
package cpuPkg;

  // Data and instruction word
  typedef logic [15:0] word_t;
  // Word address for both memories
  typedef logic [15:0] addr_t;
  // Register index, also used for shift amounts
  typedef logic [3:0] regAddr_t;

  // Top four instruction bits
  typedef enum logic [3:0] {
    opAdd    = 4'b0000,
    opAddz   = 4'b0001,
    opSub    = 4'b0010,
    opAnd    = 4'b0011,
    opNor    = 4'b0100,
    opSll    = 4'b0101,
    opSrl    = 4'b0110,
    opSra    = 4'b0111,
    opLw     = 4'b1000,
    opSw     = 4'b1001,
    opLhb    = 4'b1010,
    opLlb    = 4'b1011,
    opBranch = 4'b1100,
    opJal    = 4'b1101,
    opJr     = 4'b1110,
    opHalt   = 4'b1111
  } opcode_t;

  // Low opcode bits double as the ALU code for opcodes 0000 to 0111
  typedef enum logic [2:0] {
    aluAdd = 3'b000,
    aluLhb = 3'b001,
    aluSub = 3'b010,
    aluAnd = 3'b011,
    aluNor = 3'b100,
    aluSll = 3'b101,
    aluSrl = 3'b110,
    aluSra = 3'b111
  } aluOp_t;

  // Branch conditions on the flags, taken from instr[11:9]
  typedef enum logic [2:0] {
    condNe     = 3'b000,
    condEq     = 3'b001,
    condGt     = 3'b010,
    condLt     = 3'b011,
    condGe     = 3'b100,
    condLe     = 3'b101,
    condOv     = 3'b110,
    condAlways = 3'b111
  } branchCond_t;

  typedef enum logic [1:0] {
    stRun     = 2'd0,
    stMemWait = 2'd1,
    stHalted  = 2'd2
  } execState_t;

endpackage

// ==== rtl/execute.sv ====
`timescale 1ns/1ps

module execute (
  input  logic             clk,
  input  logic             rstN,
  input  logic             notEmpty,
  input  cpuPkg::word_t    headInstr,
  input  cpuPkg::addr_t    headPc,
  output logic             pop,
  output logic             redirect,
  output cpuPkg::addr_t    redirectTarget,
  output logic             memReq,
  output logic             memWe,
  output cpuPkg::addr_t    memAddr,
  output cpuPkg::word_t    memWdata,
  input  cpuPkg::word_t    memRdata,
  input  logic             memReady,
  output logic             retireValid,
  output logic             retireWe,
  output cpuPkg::addr_t    retirePc,
  output cpuPkg::regAddr_t retireReg,
  output cpuPkg::word_t    retireData,
  output logic             halted
);

  cpuPkg::execState_t state;

  // Decoder outputs
  logic [11:0]         imm;
  cpuPkg::regAddr_t    p0Addr, p1Addr, regAddr, shamt;
  cpuPkg::aluOp_t      aluOp;
  cpuPkg::branchCond_t branchOp;
  logic regWe, memRe, decMemWe, memToReg, addz, branch, jal, jr;
  logic aluSrc0, aluSrc1, ovEn, zrEn, neEn, halt;

  cpuPkg::word_t rData0, rData1, aluA, aluB, aluResult, wbData;
  cpuPkg::addr_t pcPlus1;
  logic aluOv, aluZr, aluNe;
  logic flagOv, flagZr, flagNe;
  logic active, isMem, done, wbWe, condTrue, taken;

  ID decoder (
    .instr(headInstr), .imm(imm), .p0Addr(p0Addr), .p1Addr(p1Addr),
    .regAddr(regAddr), .shamt(shamt), .aluOp(aluOp), .branchOp(branchOp),
    .regWe(regWe), .memRe(memRe), .memWe(decMemWe), .memToReg(memToReg),
    .addz(addz), .branch(branch), .jal(jal), .jr(jr), .aluSrc0(aluSrc0),
    .aluSrc1(aluSrc1), .ovEn(ovEn), .zrEn(zrEn), .neEn(neEn), .halt(halt)
  );

  regFile regs (
    .clk(clk), .rstN(rstN), .we(wbWe), .wAddr(regAddr), .rAddr0(p0Addr),
    .rAddr1(p1Addr), .wData(wbData), .rData0(rData0), .rData1(rData1)
  );

  // llb and lhb pair port 1 with the sign-extended immediate byte
  assign aluA = aluSrc0 ? rData1 : rData0;
  assign aluB = aluSrc0 ? {{8{imm[7]}}, imm[7:0]} :
                aluSrc1 ? {{12{imm[3]}}, imm[3:0]} : rData1;

  alu aluUnit (
    .a(aluA), .b(aluB), .aluOp(aluOp), .shamt(shamt),
    .result(aluResult), .ov(aluOv), .zr(aluZr), .ne(aluNe)
  );

  // Head is live until halt
  assign active = notEmpty && (state != cpuPkg::stHalted);
  assign isMem  = memRe | decMemWe;
  // Memory ops hold the head until the data memory answers
  assign done   = active && (!isMem || memReady);

  assign memReq   = active && isMem;
  assign memWe    = active && decMemWe;
  assign memAddr  = aluResult;
  assign memWdata = rData1;

  always_comb begin
    case (branchOp)
      cpuPkg::condNe: condTrue = !flagZr;
      cpuPkg::condEq: condTrue = flagZr;
      cpuPkg::condGt: condTrue = !flagZr && !flagNe;
      cpuPkg::condLt: condTrue = flagNe;
      cpuPkg::condGe: condTrue = !flagNe;
      cpuPkg::condLe: condTrue = flagNe || flagZr;
      cpuPkg::condOv: condTrue = flagOv;
      default:        condTrue = 1'b1;
    endcase
  end

  assign pcPlus1 = headPc + 16'd1;
  assign taken   = (branch && condTrue) || jal || jr;

  // Fires with the pop so the queue flush drops the wrong-path entries
  assign redirect       = done && taken;
  assign redirectTarget = jr ? rData0 :
                          jal ? pcPlus1 + {{4{imm[11]}}, imm} :
                          pcPlus1 + {{7{imm[8]}}, imm[8:0]};

  // addz looks at the zero flag left by the previous instruction
  assign wbWe   = done && regWe && (!addz || flagZr);
  assign wbData = memToReg ? memRdata : (jal ? pcPlus1 : aluResult);

  assign pop         = done;
  assign retireValid = done;
  assign retireWe    = wbWe;
  assign retirePc    = headPc;
  assign retireReg   = regAddr;
  assign retireData  = wbData;
  assign halted      = state == cpuPkg::stHalted;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state  <= cpuPkg::stRun;
      flagOv <= 1'b0;
      flagZr <= 1'b0;
      flagNe <= 1'b0;
    end else begin
      if (done && ovEn) flagOv <= aluOv;
      if (done && zrEn) flagZr <= aluZr;
      if (done && neEn) flagNe <= aluNe;
      case (state)
        cpuPkg::stRun: begin
          if (done && halt) begin
            state <= cpuPkg::stHalted;
          end else if (active && isMem && !memReady) begin
            state <= cpuPkg::stMemWait;
          end
        end
        cpuPkg::stMemWait: begin
          if (memReady) state <= cpuPkg::stRun;
        end
        default: state <= cpuPkg::stHalted;
      endcase
    end
  end

endmodule

// ==== rtl/fetch.sv ====
`timescale 1ns/1ps

module fetch #(
  parameter int queueDepth = 4
) (
  input  logic          clk,
  input  logic          rstN,
  input  logic          creditReturn,
  input  logic          redirect,
  input  cpuPkg::addr_t redirectTarget,
  output cpuPkg::addr_t instrAddr,
  input  cpuPkg::word_t instrData,
  output logic          push,
  output cpuPkg::word_t pushInstr,
  output cpuPkg::addr_t pushPc
);

  // Wide enough to hold a full set of credits
  localparam int creditW = $clog2(queueDepth + 1);

  cpuPkg::addr_t pc;
  logic [creditW-1:0] credits;

  // One credit per free queue slot, nothing goes out while execute redirects
  assign push = (credits != '0) && !redirect;

  // Memory answers in the same cycle
  assign instrAddr = pc;
  assign pushInstr = instrData;
  assign pushPc    = pc;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc      <= '0;
      credits <= creditW'(queueDepth);
    end else if (redirect) begin
      // Queue is flushed in this cycle so every slot is free again
      pc      <= redirectTarget;
      credits <= creditW'(queueDepth);
    end else begin
      if (push) begin
        pc <= pc + 16'd1;
      end
      // Return and spend can coincide and cancel out
      if (creditReturn && !push) begin
        credits <= credits + 1'b1;
      end else if (!creditReturn && push) begin
        credits <= credits - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/instrQueue.sv ====
`timescale 1ns/1ps

module instrQueue #(
  parameter int queueDepth = 4
) (
  input  logic          clk,
  input  logic          rstN,
  input  logic          push,
  input  logic          pop,
  input  logic          flush,
  input  cpuPkg::word_t pushInstr,
  input  cpuPkg::addr_t pushPc,
  output logic          notEmpty,
  output logic          creditReturn,
  output cpuPkg::word_t headInstr,
  output cpuPkg::addr_t headPc
);

  localparam int ptrW   = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int countW = $clog2(queueDepth + 1);

  // Instruction and pc storage, indexed by the pointers
  cpuPkg::word_t instrMem [queueDepth];
  cpuPkg::addr_t pcMem    [queueDepth];

  logic [ptrW-1:0]   wrPtr;
  logic [ptrW-1:0]   rdPtr;
  logic [countW-1:0] count;
  logic              doPop;

  assign notEmpty  = count != '0;
  assign doPop     = pop && notEmpty;
  assign headInstr = instrMem[rdPtr];
  assign headPc    = pcMem[rdPtr];

  // Freed slot goes back to fetch, unless the flush hands out a full set anyway
  assign creditReturn = doPop && !flush;

  // Payload write, fetch never pushes into a full queue
  always_ff @(posedge clk) begin
    if (push && !flush) begin
      instrMem[wrPtr] <= pushInstr;
      pcMem[wrPtr]    <= pushPc;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else if (flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Occupancy only moves when exactly one side is active
      if (push && !doPop) begin
        count <= count + 1'b1;
      end else if (!push && doPop) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic             clk,
  input  logic             rstN,
  input  logic             we,
  input  cpuPkg::regAddr_t wAddr,
  input  cpuPkg::regAddr_t rAddr0,
  input  cpuPkg::regAddr_t rAddr1,
  input  cpuPkg::word_t    wData,
  output cpuPkg::word_t    rData0,
  output cpuPkg::word_t    rData1
);

  cpuPkg::word_t regs [16];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wAddr != 4'h0)) begin
      regs[wAddr] <= wData;
    end
  end

  // R0 is hardwired to zero on both ports
  assign rData0 = (rAddr0 == 4'h0) ? '0 : regs[rAddr0];
  assign rData1 = (rAddr1 == 4'h0) ? '0 : regs[rAddr1];

endmodule

// ==== testbench/cpuCoreTb.sv ====
`timescale 1ns/1ps

module cpuCoreTb;

  localparam int queueDepth  = 4;
  localparam int resetCycles = 10;
  // Idle cycles watched once halted is up
  localparam int tailCycles  = 20;

  // Instruction classes the program generator draws from
  localparam int kindAlu    = 1;
  localparam int kindAddz   = 2;
  localparam int kindBranch = 4;
  localparam int kindJump   = 8;
  localparam int kindMem    = 16;

  logic             clk = 1'b0;
  logic             rstN;
  cpuPkg::addr_t    instrAddr;
  cpuPkg::word_t    instrData;
  logic             memReq;
  logic             memWe;
  logic             memReady;
  cpuPkg::addr_t    memAddr;
  cpuPkg::word_t    memWdata;
  cpuPkg::word_t    memRdata;
  logic             retireValid;
  logic             retireWe;
  logic             halted;
  cpuPkg::addr_t    retirePc;
  cpuPkg::regAddr_t retireReg;
  cpuPkg::word_t    retireData;

  // Program ROM, everything past the program is halt
  cpuPkg::word_t rom [256];
  // Only written words are stored, the rest reads the fill pattern
  cpuPkg::word_t dmem [cpuPkg::addr_t];
  cpuPkg::word_t refMem [cpuPkg::addr_t];

  // Expected retire and store sequences from the ISA model
  cpuPkg::addr_t    expPc [$];
  logic             expWe [$];
  cpuPkg::regAddr_t expReg [$];
  cpuPkg::word_t    expData [$];
  cpuPkg::addr_t    expStAddr [$];
  cpuPkg::word_t    expStData [$];

  int errors = 0;
  int tests = 0;
  int failedTests = 0;
  int retired = 0;
  int cycles = 0;
  int cycleLimit = 0;

  cpuCore #(.queueDepth(queueDepth)) UUT (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instrData(instrData),
    .memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
    .memRdata(memRdata), .memReady(memReady), .retireValid(retireValid),
    .retireWe(retireWe), .retirePc(retirePc), .retireReg(retireReg),
    .retireData(retireData), .halted(halted)
  );

  // Instruction memory answers in the same cycle
  assign instrData = rom[instrAddr[7:0]];

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Timeout after %0d cycles without the program reaching halt", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic cpuPkg::word_t fillWord(input cpuPkg::addr_t a);
    return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ 16'hc3a5;
  endfunction

  // Branch condition table of the ISA
  function automatic logic condHolds(input logic [2:0] cond, input logic z, input logic n,
                                     input logic v);
    case (cond)
      3'd0: return !z;
      3'd1: return z;
      3'd2: return !z && !n;
      3'd3: return n;
      3'd4: return !n;
      3'd5: return n || z;
      3'd6: return v;
      default: return 1'b1;
    endcase
  endfunction

  task automatic compareValue(input string sig, input cpuPkg::word_t got,
                              input cpuPkg::word_t exp);
    assert (got == exp) else begin
      errors++;
      $display("mismatch %s: got %h expected %h", sig, got, exp);
    end
  endtask

  // Forward-only control flow, so every program runs into halt
  task automatic buildProgram(input int kinds, input int len);
    int pc;
    int cls;
    int off;
    logic [3:0] op;
    logic [3:0] r;
    logic [7:0] tgt;
    // Slots some earlier jump or branch can land on
    logic [255:0] targets;
    for (int i = 0; i < 256; i++) begin
      rom[i] = {cpuPkg::opHalt, 12'h000};
    end
    targets = '0;
    pc = 0;
    while (pc < len) begin
      cls = $urandom_range(0, 4);
      // First few slots seed registers with llb
      if (pc < 4 || ((kinds >> cls) & 1) == 0) cls = 0;
      case (cls)
        0: begin
          op = 4'($urandom_range(0, 8));
          if (pc < 4 || op == 4'h1) begin
            op = cpuPkg::opLlb;
          end else if (op == 4'h8) begin
            op = cpuPkg::opLhb;
          end
          rom[pc] = {op, 12'($urandom())};
        end
        1: rom[pc] = {cpuPkg::opAddz, 12'($urandom())};
        2: begin
          off = $urandom_range(0, 3);
          rom[pc] = {cpuPkg::opBranch, 3'($urandom()), 9'(off)};
          targets[8'(pc + 1 + off)] = 1'b1;
        end
        3: begin
          // A jr that could be entered past its llb would follow a stale register
          if ($urandom_range(0, 1) == 0 || pc + 1 >= len || targets[8'(pc + 1)]) begin
            off = $urandom_range(0, 3);
            rom[pc] = {cpuPkg::opJal, 12'(off)};
            targets[8'(pc + 1 + off)] = 1'b1;
          end else begin
            // llb loads a forward target that jr then follows
            r = 4'($urandom_range(1, 14));
            tgt = 8'(pc + 2 + $urandom_range(0, 3));
            targets[tgt] = 1'b1;
            rom[pc] = {cpuPkg::opLlb, r, tgt};
            pc++;
            rom[pc] = {cpuPkg::opJr, 4'h0, r, 4'h0};
          end
        end
        default: begin
          op = ($urandom_range(0, 1) == 0) ? cpuPkg::opLw : cpuPkg::opSw;
          rom[pc] = {op, 12'($urandom())};
        end
      endcase
      pc++;
    end
  endtask

  // ISA reference model, runs the ROM program to halt
  task automatic runModel();
    cpuPkg::word_t regs [16];
    cpuPkg::word_t w, a, b, res;
    cpuPkg::addr_t pc, next, addr;
    logic fz, fn, fv, we;
    logic [3:0] op, wr;
    int steps;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    refMem.delete();
    expPc.delete();
    expWe.delete();
    expReg.delete();
    expData.delete();
    expStAddr.delete();
    expStData.delete();
    pc = '0;
    fz = 1'b0;
    fn = 1'b0;
    fv = 1'b0;
    op = 4'h0;
    steps = 0;
    while (op != 4'hf && steps < 1000) begin
      w = rom[pc[7:0]];
      op = w[15:12];
      a = regs[w[7:4]];
      b = regs[w[3:0]];
      res = '0;
      we = 1'b1;
      wr = w[11:8];
      next = pc + 16'd1;
      addr = a + {{12{w[3]}}, w[3:0]};
      case (op)
        4'h0, 4'h1: begin
          res = a + b;
          fv = (a[15] == b[15]) && (res[15] != a[15]);
          fn = res[15];
          // addz writes only while the zero flag from earlier instructions is set
          we = (op == 4'h0) || fz;
        end
        4'h2: begin
          res = a - b;
          fv = (a[15] != b[15]) && (res[15] != a[15]);
          fn = res[15];
        end
        4'h3: res = a & b;
        4'h4: res = ~(a | b);
        4'h5: res = a << w[3:0];
        4'h6: res = a >> w[3:0];
        4'h7: res = cpuPkg::word_t'($signed(a) >>> w[3:0]);
        4'h8: res = refMem.exists(addr) ? refMem[addr] : fillWord(addr);
        4'h9: begin
          we = 1'b0;
          expStAddr.push_back(addr);
          expStData.push_back(regs[wr]);
          refMem[addr] = regs[wr];
        end
        4'ha: res = {w[7:0], regs[wr][7:0]};
        4'hb: res = {{8{w[7]}}, w[7:0]};
        4'hc: begin
          we = 1'b0;
          if (condHolds(w[11:9], fz, fn, fv)) next = next + {{7{w[8]}}, w[8:0]};
        end
        4'hd: begin
          // Link register is R15
          res = next;
          wr = 4'hf;
          next = next + {{4{w[11]}}, w[11:0]};
        end
        4'he: begin
          we = 1'b0;
          next = a;
        end
        default: we = 1'b0;
      endcase
      // Zero flag follows every ALU opcode
      if (!op[3]) fz = res == '0;
      expPc.push_back(pc);
      expWe.push_back(we);
      expReg.push_back(wr);
      expData.push_back(res);
      if (we && wr != 4'h0) regs[wr] = res;
      pc = next;
      steps++;
    end
  endtask

  task automatic checkCycle();
    logic expMemOp;
    // Only the next instruction in program order may be waiting on the data memory
    expMemOp = (expPc.size() != 0) && (rom[expPc[0][7:0]][15:13] == 3'b100);
    assert (!memReq || expMemOp) else begin
      errors++;
      $display("memory request while no load or store is next to retire");
    end
    if (memReq && memWe && memReady) begin
      assert (expStAddr.size() != 0) else begin
        errors++;
        $display("store to address %h that the program never makes", memAddr);
      end
      if (expStAddr.size() != 0) begin
        compareValue("memAddr", memAddr, expStAddr.pop_front());
        compareValue("memWdata", memWdata, expStData.pop_front());
      end
      dmem[memAddr] = memWdata;
    end
    if (retireValid) begin
      assert (expPc.size() != 0) else begin
        errors++;
        $display("instruction at %h retired after the halt instruction", retirePc);
      end
      if (expPc.size() != 0) begin
        compareValue("retirePc", retirePc, expPc[0]);
        compareValue("retireWe", 16'(retireWe), 16'(expWe[0]));
        compareValue("memReq", 16'(memReq), 16'(expMemOp));
        if (expWe[0]) begin
          compareValue("retireReg", 16'(retireReg), 16'(expReg[0]));
          compareValue("retireData", retireData, expData[0]);
        end
        void'(expPc.pop_front());
        void'(expWe.pop_front());
        void'(expReg.pop_front());
        void'(expData.pop_front());
        retired++;
      end
    end
    assert (!halted || expPc.size() == 0) else begin
      errors++;
      $display("halted rose with %0d instructions still to retire", expPc.size());
    end
  endtask

  task automatic runTest(input string name, input int stallPct);
    int errStart;
    int tail;
    errStart = errors;
    tail = 0;
    retired = 0;
    runModel();
    cycleLimit = cycles + 8 * expPc.size() + resetCycles + tailCycles + 2;
    dmem.delete();
    @(posedge clk);
    #1;
    rstN = 1'b0;
    memReady = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
    while (tail < tailCycles) begin
      // Random back-pressure from the data memory
      memReady = $urandom_range(0, 99) >= stallPct;
      // Read data for the address the core holds in this cycle
      memRdata = dmem.exists(memAddr) ? dmem[memAddr] : fillWord(memAddr);
      @(negedge clk);
      #1;
      checkCycle();
      if (halted) tail++;
      @(posedge clk);
      #1;
    end
    assert (expPc.size() == 0 && expStAddr.size() == 0) else begin
      errors++;
      $display("%0d instructions and %0d stores missing at the end of the run",
               expPc.size(), expStAddr.size());
    end
    tests++;
    if (errors != errStart) failedTests++;
    $display("test %0d %s: %0d retired, %0d errors", tests, name, retired, errors - errStart);
  endtask

  initial begin
    void'($urandom(32'ha585_8de3));
    rstN = 1'b0;
    memReady = 1'b0;
    memRdata = '0;
    for (int rep = 0; rep < 3; rep++) begin
      buildProgram(kindAlu, 32);
      runTest("alu and logic", 0);
      buildProgram(kindAlu | kindAddz | kindBranch, 32);
      runTest("flags and branches", 0);
      buildProgram(kindAlu | kindJump, 32);
      runTest("jal and jr", 0);
      // Same program without and with stalls
      buildProgram(kindAlu | kindMem, 32);
      runTest("loads and stores", 0);
      runTest("loads and stores with stalls", 50);
      buildProgram(kindAlu | kindAddz | kindBranch | kindJump | kindMem, 48);
      runTest("mixed program with stalls", 40);
    end
    $display("%0d tests run, %0d with errors, %0d errors in total", tests, failedTests, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
